// File: Bender.yml
package:
  name: ikari_inputs

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ikari_inputs_pkg.sv
      - rtl/controller_scan.sv
      - rtl/player_controls.sv
      - rtl/cabinet_inputs.sv
      - rtl/ikari_inputs.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/ikari_inputs_chk.sv
      - test/tb_ikari_inputs.sv

// File: ikari_inputs.f
+incdir+rtl
rtl/ikari_inputs_pkg.sv
rtl/controller_scan.sv
rtl/player_controls.sv
rtl/cabinet_inputs.sv
rtl/ikari_inputs.sv
test/ikari_inputs_chk.sv
test/tb_ikari_inputs.sv

// File: rtl/cabinet_inputs.sv
//========================================
// Registered player words and pause latch
//========================================
`timescale 1ns/1ps
`include "ikari_inputs_defs.svh"

module cabinet_inputs (
	input  logic                                clk_53p6,
	input  logic                                reset,
	input  ikari_inputs_pkg::player_req_t [1:0] req,
	output ikari_inputs_pkg::player_word_t      player1,
	output ikari_inputs_pkg::player_word_t      player2,
	output logic                                pause_cpu
);
	import ikari_inputs_pkg::*;

	// Nothing pressed, stick at home
	localparam player_word_t WORD_IDLE = '{
		fixed_hi:  2'b11,
		up_n:      1'b1,
		down_n:    1'b1,
		right_n:   1'b1,
		left_n:    1'b1,
		service_n: 1'b1,
		fixed_mid: 1'b1,
		rot:       `ROT_HOME,
		grenade_n: 1'b1,
		shot_n:    1'b1,
		start_n:   1'b1,
		coin_n:    1'b1
	};

	logic pause_any;
	logic pause_prev;

	// Either player can pause
	assign pause_any = req[0].pause | req[1].pause;

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			player1    <= WORD_IDLE;
			player2    <= WORD_IDLE;
			pause_prev <= 1'b0;
			pause_cpu  <= 1'b0;
		end else begin
			player1    <= req[0].word;
			player2    <= req[1].word;
			pause_prev <= pause_any;
			// Toggle once per press, holding does nothing more
			if (pause_any && !pause_prev)
				pause_cpu <= ~pause_cpu;
		end
	end

endmodule

// File: rtl/controller_scan.sv
//========================================
// DB15 serial adapter scanner and the
// shared rotary step tick
//========================================
`timescale 1ns/1ps
`include "ikari_inputs_defs.svh"

module controller_scan #(
	parameter int ROT_DIV_BITS = 23
) (
	input  logic                         clk_53p6,
	input  logic                         reset,
	input  ikari_inputs_pkg::rot_speed_t rot_speed,
	input  logic                         joy_data,
	output logic                         joy_load,
	output logic                         joy_clk,
	output ikari_inputs_pkg::pad_t [1:0] db15_pad,
	output logic                         frame_done,
	output logic                         rot_tick
);
	import ikari_inputs_pkg::*;

	// Both pads in one frame
	localparam int FRAME_BITS = 2 * `PAD_W;
	// Load period plus one period per bit, counted in half periods
	localparam int HALVES = 2 * (FRAME_BITS + 1);
	localparam int DIV_W = $clog2(`DB15_CLK_DIV + 1);
	localparam int HALF_W = $clog2(HALVES + 1);

	logic [DIV_W-1:0]        div_cnt;
	logic [HALF_W-1:0]       half_cnt;
	logic                    half_end;
	logic                    frame_end;
	logic                    load_next;
	logic                    clk_next;
	logic [FRAME_BITS-1:0]   shift_reg;
	logic [ROT_DIV_BITS-1:0] rot_div;

	//========================================
	// DB15 frame sequencer
	//========================================

	// Last system clock of a half period
	assign half_end = (div_cnt == DIV_W'(`DB15_CLK_DIV - 1));
	assign frame_end = half_end && (half_cnt == HALF_W'(HALVES - 1));

	// First two halves are the load pulse
	assign load_next = (half_cnt < HALF_W'(2));
	// Clock high on every even half after the load
	assign clk_next = !load_next && !half_cnt[0];

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			div_cnt    <= '0;
			half_cnt   <= '0;
			joy_load   <= 1'b0;
			joy_clk    <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// Pins follow the half counter by one clock
			joy_load   <= load_next;
			joy_clk    <= clk_next;
			frame_done <= frame_end;
			if (half_end) begin
				div_cnt <= '0;
				if (frame_end)
					half_cnt <= '0;
				else
					half_cnt <= half_cnt + 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Sample on the clock that raises joy_clk, MSB first
	// Adapter drives active low, store as pressed = 1
	always_ff @(posedge clk_53p6) begin
		if (clk_next && !joy_clk)
			shift_reg <= {shift_reg[FRAME_BITS-2:0], ~joy_data};
	end

	// Pad 1 went in first so it sits in the upper half
	always_ff @(posedge clk_53p6) begin
		if (reset)
			db15_pad <= '0;
		else if (frame_end)
			db15_pad <= {shift_reg[`PAD_W-1:0], shift_reg[FRAME_BITS-1:`PAD_W]};
	end

	//========================================
	// Rotary step tick
	//========================================

	always_ff @(posedge clk_53p6) begin
		if (reset)
			rot_div <= '0;
		else
			rot_div <= rot_div + 1'b1;
	end

	// Fewer low bits checked means a faster tick
	always_comb begin
		case (rot_speed)
			ROT_SLOW:  rot_tick = (rot_div == '0);
			ROT_FAST:  rot_tick = (rot_div[ROT_DIV_BITS-3:0] == '0);
			ROT_VFAST: rot_tick = (rot_div[ROT_DIV_BITS-4:0] == '0);
			default:   rot_tick = (rot_div[ROT_DIV_BITS-2:0] == '0);
		endcase
	end

endmodule

// File: rtl/ikari_inputs.sv
//========================================
// Player input path top level
//========================================
`timescale 1ns/1ps

module ikari_inputs #(
	parameter int ROT_DIV_BITS = 23
) (
	input  logic                           clk_53p6,
	input  logic                           reset,
	input  ikari_inputs_pkg::pad_t [1:0]   pad_hps,
	input  ikari_inputs_pkg::snac_cfg_t    snac_cfg,
	input  ikari_inputs_pkg::rot_speed_t   rot_speed,
	input  logic                           joy_data,
	output logic                           joy_load,
	output logic                           joy_clk,
	output ikari_inputs_pkg::player_word_t player1,
	output ikari_inputs_pkg::player_word_t player2,
	output logic                           pause_cpu
);
	import ikari_inputs_pkg::*;

	pad_t [1:0]        db15_pad;
	logic              frame_done;
	logic              rot_tick;
	player_req_t [1:0] req;

	// One scanner serves both DB15 ports
	controller_scan #(
		.ROT_DIV_BITS(ROT_DIV_BITS)
	) u_scan (
		.clk_53p6  (clk_53p6),
		.reset     (reset),
		.rot_speed (rot_speed),
		.joy_data  (joy_data),
		.joy_load  (joy_load),
		.joy_clk   (joy_clk),
		.db15_pad  (db15_pad),
		.frame_done(frame_done),
		.rot_tick  (rot_tick)
	);

	// Index 0 is player 1
	for (genvar plr = 0; plr < 2; plr++) begin : g_player
		player_controls u_ctrl (
			.clk_53p6  (clk_53p6),
			.reset     (reset),
			.mode      ((plr == 0) ? snac_cfg.p1 : snac_cfg.p2),
			.pad_hps   (pad_hps[plr]),
			.db15_pad  (db15_pad[plr]),
			.frame_done(frame_done),
			.rot_tick  (rot_tick),
			.req       (req[plr])
		);
	end

	cabinet_inputs u_cab (
		.clk_53p6 (clk_53p6),
		.reset    (reset),
		.req      (req),
		.player1  (player1),
		.player2  (player2),
		.pause_cpu(pause_cpu)
	);

endmodule

// File: rtl/ikari_inputs_defs.svh
//========================================
// Widths, DB15 divider and rotary constants
// for the player input path
//========================================
`ifndef IKARI_INPUTS_DEFS_SVH
`define IKARI_INPUTS_DEFS_SVH

// Width of one gamepad word, host or DB15
`define PAD_W 16

// System clocks per half period of the DB15 clock
`define DB15_CLK_DIV 4

// Rotary stick positions, counted 0 to 11
`define ROT_POSITIONS 12

// Position after reset
`define ROT_HOME 11

// Width of the rot field in the cabinet word
`define ROT_W 4

`endif

// File: rtl/ikari_inputs_pkg.sv
//========================================
// Source and speed enums, pad and cabinet
// word structs
//========================================
`include "ikari_inputs_defs.svh"

package ikari_inputs_pkg;

	// Where a player's buttons come from
	typedef enum logic [1:0] {
		SNAC_OFF  = 2'd0,
		SNAC_DB15 = 2'd1,
		SNAC_LS30 = 2'd2
	} snac_mode_t;

	// Rotary step rate for button driven rotation
	typedef enum logic [1:0] {
		ROT_NORMAL = 2'd0,
		ROT_SLOW   = 2'd1,
		ROT_FAST   = 2'd2,
		ROT_VFAST  = 2'd3
	} rot_speed_t;

	// Bit n high means button n pressed
	typedef logic [`PAD_W-1:0] pad_t;

	// Source select for both players
	typedef struct packed {
		snac_mode_t p2;
		snac_mode_t p1;
	} snac_cfg_t;

	// Cabinet input word, MSB first
	// Buttons and directions are active low
	typedef struct packed {
		logic [1:0]        fixed_hi;
		logic              up_n;
		logic              down_n;
		logic              right_n;
		logic              left_n;
		logic              service_n;
		logic              fixed_mid;
		logic [`ROT_W-1:0] rot;
		logic              grenade_n;
		logic              shot_n;
		logic              start_n;
		logic              coin_n;
	} player_word_t;

	// Word plus the pause request, active high
	typedef struct packed {
		player_word_t word;
		logic         pause;
	} player_req_t;

endpackage

// File: rtl/player_controls.sv
//========================================
// Per player source select, button map,
// rotary counter and LS-30 decoder
//========================================
`timescale 1ns/1ps
`include "ikari_inputs_defs.svh"

module player_controls (
	input  logic                          clk_53p6,
	input  logic                          reset,
	input  ikari_inputs_pkg::snac_mode_t  mode,
	input  ikari_inputs_pkg::pad_t        pad_hps,
	input  ikari_inputs_pkg::pad_t        db15_pad,
	input  logic                          frame_done,
	input  logic                          rot_tick,
	output ikari_inputs_pkg::player_req_t req
);
	import ikari_inputs_pkg::*;

	localparam logic [`ROT_W-1:0] ROT_LAST = `ROT_POSITIONS - 1;
	localparam logic [`ROT_W-1:0] ROT_START = `ROT_HOME;

	// Decoded buttons, all active high
	logic up;
	logic down;
	logic left;
	logic right;
	logic shot;
	logic grenade;
	logic start;
	logic coin;
	logic rot_left;
	logic rot_right;
	logic service;
	logic pause;

	logic [`ROT_W-1:0] rot_pos;
	logic [`ROT_W-1:0] ls30_code;
	logic [`ROT_W-1:0] ls30_prev;
	logic [`ROT_W-1:0] ls30_pos;

	//========================================
	// Button mapping
	//========================================

	always_comb begin
		// Directions share the same bits on every source
		up    = pad_hps[3];
		down  = pad_hps[2];
		left  = pad_hps[1];
		right = pad_hps[0];
		case (mode)
			SNAC_DB15: begin
				up        = db15_pad[3];
				down      = db15_pad[2];
				left      = db15_pad[1];
				right     = db15_pad[0];
				// B shoots, C throws
				shot      = db15_pad[5];
				grenade   = db15_pad[6];
				start     = db15_pad[10];
				coin      = db15_pad[11];
				// A and D turn the stick
				rot_left  = db15_pad[4];
				rot_right = db15_pad[7];
				// Select combos
				service   = db15_pad[5] & db15_pad[11];
				pause     = db15_pad[4] & db15_pad[11];
			end
			SNAC_LS30: begin
				up        = db15_pad[3];
				down      = db15_pad[2];
				left      = db15_pad[1];
				right     = db15_pad[0];
				// Stick has A and B only
				shot      = db15_pad[4];
				grenade   = db15_pad[5];
				start     = db15_pad[10];
				coin      = db15_pad[11];
				// Position comes from the stick code instead
				rot_left  = 1'b0;
				rot_right = 1'b0;
				service   = db15_pad[5] & db15_pad[11];
				pause     = db15_pad[4] & db15_pad[11];
			end
			default: begin
				shot      = pad_hps[4];
				grenade   = pad_hps[5];
				start     = pad_hps[6];
				coin      = pad_hps[7];
				rot_left  = pad_hps[8];
				rot_right = pad_hps[9];
				service   = pad_hps[10];
				pause     = pad_hps[11];
			end
		endcase
	end

	//========================================
	// Button driven rotary counter
	//========================================

	// Left wins when both are held
	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			rot_pos <= ROT_START;
		end else if (rot_tick) begin
			if (rot_left)
				rot_pos <= (rot_pos == ROT_LAST) ? '0 : rot_pos + 1'b1;
			else if (rot_right)
				rot_pos <= (rot_pos == '0) ? ROT_LAST : rot_pos - 1'b1;
		end
	end

	//========================================
	// LS-30 position decoder
	//========================================

	// Stick code rides on buttons C to F
	assign ls30_code = db15_pad[9:6];

	// Take a code only once two frames agree and it is a real position
	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			ls30_prev <= '1;
			ls30_pos  <= ROT_START;
		end else if (frame_done) begin
			ls30_prev <= ls30_code;
			if (ls30_code == ls30_prev && ls30_code <= ROT_LAST)
				ls30_pos <= ls30_code;
		end
	end

	// Cabinet word, active low buttons
	always_comb begin
		req.word.fixed_hi  = 2'b11;
		req.word.up_n      = ~up;
		req.word.down_n    = ~down;
		req.word.right_n   = ~right;
		req.word.left_n    = ~left;
		req.word.service_n = ~service;
		req.word.fixed_mid = 1'b1;
		req.word.rot       = (mode == SNAC_LS30) ? ls30_pos : rot_pos;
		req.word.grenade_n = ~grenade;
		req.word.shot_n    = ~shot;
		req.word.start_n   = ~start;
		req.word.coin_n    = ~coin;
		req.pause          = pause;
	end

endmodule

// File: test/ikari_inputs_chk.sv
//========================================
// Bound port checks for the input path
//========================================
`timescale 1ns/1ps
`include "ikari_inputs_defs.svh"

module ikari_inputs_chk (
	input logic                           clk_53p6,
	input logic                           reset,
	input logic                           joy_load,
	input logic                           joy_clk,
	input ikari_inputs_pkg::player_word_t player1,
	input ikari_inputs_pkg::player_word_t player2
);

	// Failed assertions so far
	int fail_count = 0;

	// Load and clock pulses never overlap on the DB15 port
	a_load_clk: assert property (@(posedge clk_53p6) disable iff (reset)
		!(joy_load && joy_clk))
		else begin
			fail_count++;
			$error("joy_load and joy_clk are high together");
		end

	// Bits 15, 14 and 8 are tied high in the cabinet word
	a_fixed_bits: assert property (@(posedge clk_53p6) disable iff (reset)
		(player1.fixed_hi == 2'b11) && player1.fixed_mid &&
		(player2.fixed_hi == 2'b11) && player2.fixed_mid)
		else begin
			fail_count++;
			$error("fixed bits of a player word are not all high");
		end

	// Only twelve stick positions exist
	a_rot_range: assert property (@(posedge clk_53p6) disable iff (reset)
		(player1.rot < `ROT_POSITIONS) && (player2.rot < `ROT_POSITIONS))
		else begin
			fail_count++;
			$error("rot field of a player word is out of range");
		end

endmodule

bind ikari_inputs ikari_inputs_chk u_chk (.*);

// File: test/tb_ikari_inputs.sv
//========================================
// Testbench for the player input path
//========================================
`timescale 1ns/1ps
`include "ikari_inputs_defs.svh"

module tb_ikari_inputs;
	import ikari_inputs_pkg::*;

	// One DB15 frame is 264 clocks
	localparam int LOAD_WAIT = 100 * `DB15_CLK_DIV;
	localparam int ROT_STEPS = 14;
	// Everything except the rot field
	localparam logic [15:0] ROT_MASKED = 16'hFF0F;

	logic         clk_53p6 = 1'b0;
	logic         reset = 1'b1;
	pad_t [1:0]   pad_hps = '0;
	snac_cfg_t    snac_cfg = '{p2: SNAC_OFF, p1: SNAC_OFF};
	rot_speed_t   rot_speed = ROT_NORMAL;
	logic         joy_data;
	logic         joy_load;
	logic         joy_clk;
	player_word_t player1;
	player_word_t player2;
	logic         pause_cpu;

	// DB15 adapter model, index 0 is player 1
	pad_t [1:0]  adapter_pad = '0;
	logic [31:0] frame_bits;
	int          bit_idx = 0;

	integer seed = 32'h84c73d7b;
	int     mismatches = 0;
	int     timeouts = 0;
	logic   exp_pause = 1'b0;

	ikari_inputs #(.ROT_DIV_BITS(6)) DUT (.*);

	initial begin
		forever #20 clk_53p6 = ~clk_53p6;
	end

	//========================================
	// DB15 adapter model
	//========================================

	// Pad 1 shifts out first, MSB first, pressed drives low
	assign frame_bits = {adapter_pad[0], adapter_pad[1]};
	assign joy_data = (bit_idx < 32) ? ~frame_bits[31 - bit_idx] : 1'b1;

	// Load restarts at the MSB, each clock rise moves one bit on
	always @(posedge joy_load or posedge joy_clk) begin
		#1;
		if (joy_load)
			bit_idx = 0;
		else
			bit_idx = bit_idx + 1;
	end

	//========================================
	// Helpers
	//========================================

	task automatic next_cycle();
		@(posedge clk_53p6);
		#1;
	endtask

	// Count rising edges of joy_load, each one ends a frame
	task automatic wait_loads(input int n);
		int   seen;
		int   cycles;
		logic prev;
		seen = 0;
		cycles = 0;
		prev = joy_load;
		while (seen < n && cycles < n * LOAD_WAIT) begin
			next_cycle();
			cycles++;
			if (joy_load && !prev)
				seen++;
			prev = joy_load;
		end
		if (seen < n) begin
			timeouts++;
			$display("Timed out at %0t waiting for a DB15 load pulse", $time);
		end
	endtask

	// Cabinet word from the mapping rules, active low buttons
	function automatic player_word_t expect_word(input snac_mode_t mode, input pad_t pad,
		input logic [3:0] rot);
		logic srv;
		logic gr;
		logic sh;
		logic st;
		logic cn;
		if (mode == SNAC_OFF) begin
			sh = pad[4];
			gr = pad[5];
			st = pad[6];
			cn = pad[7];
			srv = pad[10];
		end else begin
			// Start, Select and the B plus Select service combo
			st = pad[10];
			cn = pad[11];
			srv = pad[5] & pad[11];
			sh = (mode == SNAC_LS30) ? pad[4] : pad[5];
			gr = (mode == SNAC_LS30) ? pad[5] : pad[6];
		end
		return {2'b11, ~pad[3], ~pad[2], ~pad[0], ~pad[1], ~srv, 1'b1, rot,
			~gr, ~sh, ~st, ~cn};
	endfunction

	task automatic check_word(input string what, input player_word_t got,
		input player_word_t exp, input logic [15:0] care);
		assert ((got & care) === (exp & care)) else begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pause(input string what);
		assert (pause_cpu === exp_pause) else begin
			mismatches++;
			$display("MISMATCH at %0t: %s pause_cpu %b expected %b", $time, what,
				pause_cpu, exp_pause);
		end
	endtask

	// Each change of the rot field must be one step in direction dir
	task automatic follow_rot(input int dir, input int n);
		int steps;
		int cycles;
		int prev;
		int want;
		steps = 0;
		cycles = 0;
		repeat (2) next_cycle();
		prev = player1.rot;
		while (steps < n && cycles < n * 32) begin
			next_cycle();
			cycles++;
			if (int'(player1.rot) != prev) begin
				want = (prev + dir + `ROT_POSITIONS) % `ROT_POSITIONS;
				assert (int'(player1.rot) == want) else begin
					mismatches++;
					$display("MISMATCH at %0t: rot went %0d to %0d, expected %0d", $time,
						prev, player1.rot, want);
				end
				prev = player1.rot;
				steps++;
			end
		end
		if (steps < n) begin
			timeouts++;
			$display("Timed out at %0t waiting for rotary steps", $time);
		end
	endtask

	//========================================
	// Stimulus
	//========================================

	initial begin
		repeat (4) next_cycle();
		reset = 1'b0;
		check_word("p1 after reset", player1, expect_word(SNAC_OFF, '0, 4'd11), '1);
		check_word("p2 after reset", player2, expect_word(SNAC_OFF, '0, 4'd11), '1);
		check_pause("after reset");

		// Host pads, rotate and pause buttons held back
		repeat (20) begin
			pad_hps[0] = 16'($random(seed)) & 16'hF4FF;
			pad_hps[1] = 16'($random(seed)) & 16'hF4FF;
			repeat (2) next_cycle();
			check_word("p1 host pad", player1, expect_word(SNAC_OFF, pad_hps[0], 4'd11), '1);
			check_word("p2 host pad", player2, expect_word(SNAC_OFF, pad_hps[1], 4'd11), '1);
		end
		pad_hps = '0;

		// DB15 pads without A and D so the stick stays home
		snac_cfg = '{p2: SNAC_DB15, p1: SNAC_DB15};
		repeat (4) begin
			adapter_pad[0] = 16'($random(seed)) & 16'hFF6F;
			adapter_pad[1] = 16'($random(seed)) & 16'hFF6F;
			wait_loads(3);
			repeat (2) next_cycle();
			check_word("p1 DB15", player1, expect_word(SNAC_DB15, adapter_pad[0], 4'd11), '1);
			check_word("p2 DB15", player2, expect_word(SNAC_DB15, adapter_pad[1], 4'd11), '1);
		end

		// B with Select is service
		adapter_pad[0] = 16'h0820;
		adapter_pad[1] = 16'h0000;
		wait_loads(3);
		repeat (2) next_cycle();
		check_word("p1 DB15 service", player1, expect_word(SNAC_DB15, 16'h0820, 4'd11), '1);

		// A with Select pauses, A also turns the stick
		repeat (2) begin
			adapter_pad[0] = 16'h0810;
			wait_loads(3);
			repeat (2) next_cycle();
			exp_pause = ~exp_pause;
			check_word("p1 DB15 pause", player1, expect_word(SNAC_DB15, 16'h0810, 4'd0),
				ROT_MASKED);
			check_pause("DB15 pause combo");
			adapter_pad[0] = '0;
			wait_loads(3);
		end

		// Rotate left then right at the fastest rate
		snac_cfg = '{p2: SNAC_OFF, p1: SNAC_OFF};
		rot_speed = ROT_VFAST;
		pad_hps[0] = 16'h0100;
		follow_rot(1, ROT_STEPS);
		pad_hps[0] = 16'h0200;
		follow_rot(-1, ROT_STEPS);
		pad_hps[0] = '0;
		rot_speed = ROT_NORMAL;

		// LS-30 code 7 on bits 9..6, player 2 stick at code 0
		snac_cfg = '{p2: SNAC_LS30, p1: SNAC_LS30};
		adapter_pad[0] = 16'h01C0;
		wait_loads(3);
		repeat (2) next_cycle();
		check_word("p1 LS-30 code 7", player1, expect_word(SNAC_LS30, 16'h01C0, 4'd7), '1);
		check_word("p2 LS-30 code 0", player2, expect_word(SNAC_LS30, '0, 4'd0), '1);

		// Code 13 is no position, A shoots
		adapter_pad[0] = 16'h0350;
		wait_loads(3);
		repeat (2) next_cycle();
		check_word("p1 LS-30 code 13", player1, expect_word(SNAC_LS30, 16'h0350, 4'd7), '1);

		// Host pause button, once per player
		snac_cfg = '{p2: SNAC_OFF, p1: SNAC_OFF};
		adapter_pad = '0;
		for (int plr = 1; plr >= 0; plr--) begin
			pad_hps[plr] = 16'h0800;
			repeat (2) next_cycle();
			exp_pause = ~exp_pause;
			check_pause("host pause press");
			pad_hps[plr] = '0;
			repeat (4) next_cycle();
			check_pause("host pause release");
		end

		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, DUT.u_chk.fail_count);
		if (mismatches == 0 && timeouts == 0 && DUT.u_chk.fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
